// File: Bender.yml
package:
  name: pp_front_end

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/pp_beat_pkg.sv
      - design/pp_meta_pkg.sv
      - design/pp_stream_if.sv
      - design/pp_fifo.sv
      - design/pp_source_arbiter.sv
      - design/pp_credit_tracker.sv
      - design/pp_chunk_extractor.sv
      - design/pp_front_end.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/pp_checker.sv
      - tb/tb_pp_front_end.sv

// File: design/pp_beat_pkg.sv
// Beat types and header field decode for the path parser stream
`include "pp_params.svh"

package pp_beat_pkg;

   typedef struct packed {
      logic                      sop;
      logic                      eop;
      logic [`PP_DATA_NBITS-1:0] data;
   } pp_beat_t;

   typedef logic [`PP_CHUNK_LEN_NBITS-1:0] pp_chunk_len_t;  // Bytes
   typedef logic [7:0] pp_words_t;                          // 16-byte words

   // Length field sits right below the chunk type nibble
   localparam int PP_LEN_MSB = `PP_DATA_NBITS - 1 - `PP_CHUNK_TYPE_NBITS;
   localparam int PP_LEN_LSB = PP_LEN_MSB - `PP_CHUNK_LEN_NBITS + 1;

   function automatic pp_chunk_len_t pp_hdr_len(input logic [`PP_DATA_NBITS-1:0] data);
      return data[PP_LEN_MSB:PP_LEN_LSB];
   endfunction

   function automatic pp_words_t pp_chunk_words(input pp_chunk_len_t len);
      logic [`PP_CHUNK_LEN_NBITS:0] total;
      total = len + `PP_HDR_OVERHEAD;
      return pp_words_t'((total + 15) >> 4);   // Round up to whole words
   endfunction

endpackage

// File: design/pp_chunk_extractor.sv
// Path chunk extraction: forwards chunk beats and publishes packet metadata
`timescale 1ns/10ps
`include "pp_params.svh"

module pp_chunk_extractor
   import pp_beat_pkg::*, pp_meta_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      discard,
   pp_stream_if.snk                  stream,
   output logic                      pp_valid,
   output logic                      pp_sop,
   output logic                      pp_eop,
   output logic [`PP_DATA_NBITS-1:0] pp_data,
   output logic [`PP_VB_NBITS-1:0]   pp_valid_bytes,
   output logic                      pp_meta_valid,
   output pp_meta_t                  pp_meta
);

   pp_chunk_len_t                hdr_len;
   logic [`PP_CHUNK_LEN_NBITS:0] len_m1;   // Offset of the chunk's last byte
   pp_words_t                    last_idx_q;
   pp_words_t                    last_idx;
   pp_words_t                    beat_cnt;
   pp_words_t                    beat_idx;
   logic [`PP_VB_NBITS-1:0]      last_vb_q;
   logic [`PP_VB_NBITS-1:0]      last_vb;
   logic                         sop_beat;
   logic                         in_chunk;
   logic                         out_last;

   assign sop_beat = stream.valid & stream.beat.sop;
   assign hdr_len = pp_hdr_len(stream.beat.data);
   assign len_m1 = hdr_len + (`PP_HDR_OVERHEAD - 1);

   // Header beat supplies its own limits, later beats use the latched ones
   assign last_idx = stream.beat.sop ? pp_chunk_words(hdr_len) - 1'b1 : last_idx_q;
   assign last_vb = stream.beat.sop ? len_m1[`PP_VB_NBITS-1:0] + 1'b1 : last_vb_q;
   assign beat_idx = stream.beat.sop ? '0 : beat_cnt;
   assign in_chunk = beat_idx <= last_idx;
   assign out_last = stream.valid & in_chunk & ((beat_idx == last_idx) | stream.beat.eop);

   always_ff @(posedge clk) begin
      if (rst) begin
         pp_valid <= 1'b0;
         pp_meta_valid <= 1'b0;
         beat_cnt <= '0;
      end else begin
         pp_valid <= stream.valid & in_chunk & ~discard;
         pp_meta_valid <= sop_beat;   // Also for dropped packets
         if (stream.valid) beat_cnt <= stream.beat.eop ? '0 : beat_idx + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (sop_beat) begin
         last_idx_q <= last_idx;
         last_vb_q <= last_vb;
         pp_meta <= stream.meta;
         pp_meta.discard <= discard;
      end
      pp_sop <= stream.beat.sop;
      pp_eop <= out_last;
      pp_data <= stream.beat.data;
      pp_valid_bytes <= out_last ? last_vb : '0;   // Full last beat wraps to 0
   end

endmodule

// File: design/pp_credit_tracker.sv
// Downstream buffer credit count and per-packet discard decision
`timescale 1ns/10ps
`include "pp_params.svh"

module pp_credit_tracker
   import pp_beat_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     credit_return,
   pp_stream_if.snk stream,
   output logic     discard
);

   logic [`PP_CREDIT_NBITS-1:0] credits;   // Free words downstream
   logic [`PP_CREDIT_NBITS-1:0] charge;
   pp_words_t                   words;
   logic                        sop_beat;
   logic                        no_room;
   logic                        discard_st;

   assign sop_beat = stream.valid & stream.beat.sop;
   assign words = pp_chunk_words(pp_hdr_len(stream.beat.data));
   assign no_room = words > credits;

   // Decision is made on the header beat and held until eop
   assign discard = sop_beat ? no_room : discard_st;

   // Fits in the credit width since it never exceeds the count
   assign charge = (sop_beat & ~no_room) ? words[`PP_CREDIT_NBITS-1:0] : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= `PP_BUF_CREDITS;
         discard_st <= 1'b0;
      end else begin
         credits <= credits - charge + credit_return;   // Both may happen together
         if (stream.valid) discard_st <= stream.beat.eop ? 1'b0 : discard;
      end
   end

   // Downstream returns no more words than were charged
   a_credit_cap: assert property (@(posedge clk) disable iff (rst)
      credits <= `PP_BUF_CREDITS);

endmodule

// File: design/pp_fifo.sv
// Synchronous first-word fall-through FIFO with a typed payload
`timescale 1ns/10ps

module pp_fifo #(
   parameter type payload_t   = logic,
   parameter int  depth_nbits = 4
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     wr,
   input  payload_t din,
   input  logic     rd,
   output payload_t dout,
   output logic     empty,
   output logic     full
);

   localparam int depth = 1 << depth_nbits;

   payload_t               mem [depth];
   logic [depth_nbits-1:0] wr_ptr;
   logic [depth_nbits-1:0] rd_ptr;
   logic [depth_nbits:0]   count;

   always_ff @(posedge clk) begin
      if (wr) mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (wr) wr_ptr <= wr_ptr + 1'b1;
         if (rd) rd_ptr <= rd_ptr + 1'b1;
         case ({wr, rd})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign dout = mem[rd_ptr];   // Head word visible without a read
   assign empty = count == 0;
   assign full = count == depth;

   // lh has no back-pressure, so the sender must stay within the depth
   a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr && full));
   a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd && empty));

endmodule

// File: design/pp_front_end.sv
// Path parser front end: buffers both sources, arbitrates and extracts the path chunk
`timescale 1ns/10ps
`include "pp_params.svh"

module pp_front_end
   import pp_beat_pkg::*, pp_meta_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      lh_valid,
   input  logic                      lh_sop,
   input  logic                      lh_eop,
   input  logic [`PP_DATA_NBITS-1:0] lh_data,
   input  pp_meta_t                  lh_meta,
   input  logic                      ecdsa_valid,
   input  logic                      ecdsa_sop,
   input  logic                      ecdsa_eop,
   input  logic [`PP_DATA_NBITS-1:0] ecdsa_data,
   input  pp_meta_t                  ecdsa_meta,
   output logic                      ecdsa_ready,
   output logic                      pp_valid,
   output logic                      pp_sop,
   output logic                      pp_eop,
   output logic [`PP_DATA_NBITS-1:0] pp_data,
   output logic [`PP_VB_NBITS-1:0]   pp_valid_bytes,
   output logic                      pp_meta_valid,
   output pp_meta_t                  pp_meta,
   input  logic                      credit_return
);

   logic     lh_valid_d1;
   pp_beat_t lh_beat_d1;
   pp_meta_t lh_meta_d1;
   logic     ecdsa_valid_d1;
   pp_beat_t ecdsa_beat_d1;
   pp_meta_t ecdsa_meta_d1;
   logic     credit_return_d1;
   pp_beat_t lh_fifo_beat;
   pp_meta_t lh_fifo_meta;
   logic     lh_empty;
   logic     lh_meta_empty;
   logic     lh_rd;
   logic     lh_meta_rd;
   logic     discard;

   pp_stream_if stream ();

   always_ff @(posedge clk) begin
      if (rst) begin
         lh_valid_d1 <= 1'b0;
         ecdsa_valid_d1 <= 1'b0;
         credit_return_d1 <= 1'b0;
      end else begin
         lh_valid_d1 <= lh_valid;
         ecdsa_valid_d1 <= ecdsa_valid;
         credit_return_d1 <= credit_return;
      end
   end

   always_ff @(posedge clk) begin
      lh_beat_d1 <= '{sop: lh_sop, eop: lh_eop, data: lh_data};
      lh_meta_d1 <= lh_meta;
      ecdsa_beat_d1 <= '{sop: ecdsa_sop, eop: ecdsa_eop, data: ecdsa_data};
      ecdsa_meta_d1 <= ecdsa_meta;
   end

   // Every lh beat is buffered, meta once per packet
   pp_fifo #(
      .payload_t   (pp_beat_t),
      .depth_nbits (`PP_LH_FIFO_DEPTH_NBITS)
   ) lh_beat_fifo_inst (
      .clk   (clk),
      .rst   (rst),
      .wr    (lh_valid_d1),
      .din   (lh_beat_d1),
      .rd    (lh_rd),
      .dout  (lh_fifo_beat),
      .empty (lh_empty),
      .full  ()
   );

   pp_fifo #(
      .payload_t   (pp_meta_t),
      .depth_nbits (`PP_LH_META_FIFO_DEPTH_NBITS)
   ) lh_meta_fifo_inst (
      .clk   (clk),
      .rst   (rst),
      .wr    (lh_valid_d1 & lh_beat_d1.sop),
      .din   (lh_meta_d1),
      .rd    (lh_meta_rd),
      .dout  (lh_fifo_meta),
      .empty (lh_meta_empty),
      .full  ()
   );

   pp_source_arbiter pp_source_arbiter_inst (
      .clk           (clk),
      .rst           (rst),
      .lh_beat       (lh_fifo_beat),
      .lh_empty      (lh_empty),
      .lh_meta       (lh_fifo_meta),
      .lh_meta_empty (lh_meta_empty),
      .ecdsa_valid   (ecdsa_valid_d1),
      .ecdsa_beat    (ecdsa_beat_d1),
      .ecdsa_meta    (ecdsa_meta_d1),
      .lh_rd         (lh_rd),
      .lh_meta_rd    (lh_meta_rd),
      .ecdsa_ready   (ecdsa_ready),
      .stream        (stream)
   );

   pp_credit_tracker pp_credit_tracker_inst (
      .clk           (clk),
      .rst           (rst),
      .credit_return (credit_return_d1),
      .stream        (stream),
      .discard       (discard)
   );

   pp_chunk_extractor pp_chunk_extractor_inst (
      .clk            (clk),
      .rst            (rst),
      .discard        (discard),
      .stream         (stream),
      .pp_valid       (pp_valid),
      .pp_sop         (pp_sop),
      .pp_eop         (pp_eop),
      .pp_data        (pp_data),
      .pp_valid_bytes (pp_valid_bytes),
      .pp_meta_valid  (pp_meta_valid),
      .pp_meta        (pp_meta)
   );

endmodule

// File: design/pp_meta_pkg.sv
// Per-packet metadata carried alongside the path parser stream
package pp_meta_pkg;

   typedef struct packed {
      logic [3:0]  port;
      logic [15:0] fid;
      logic [15:0] rci;
      logic        discard;     // Set when the chunk did not fit downstream
      logic        src_ecdsa;   // 1 for the signature-check source, 0 for lh
   } pp_meta_t;

   // Source flag values
   localparam logic PP_SRC_LH    = 1'b0;
   localparam logic PP_SRC_ECDSA = 1'b1;

   function automatic logic pp_is_ecdsa(input pp_meta_t meta);
      return meta.src_ecdsa == PP_SRC_ECDSA;
   endfunction

endpackage

// File: design/pp_params.svh
// Path parser constants for beat widths, header fields, FIFO depths and credits
`ifndef PP_PARAMS_SVH
`define PP_PARAMS_SVH

// Beat and header layout
`define PP_DATA_NBITS 128
`define PP_VB_NBITS 4
`define PP_CHUNK_LEN_NBITS 12
`define PP_CHUNK_TYPE_NBITS 4     // Sits above the length field
`define PP_HDR_OVERHEAD 2         // Added to the length field for the chunk total

// lh buffering
`define PP_LH_FIFO_DEPTH_NBITS 4
`define PP_LH_META_FIFO_DEPTH_NBITS 2

// Downstream buffer in 16-byte words
`define PP_CREDIT_NBITS 6
`define PP_BUF_CREDITS 32

`endif

// File: design/pp_source_arbiter.sv
// Packet-level source select between the lh FIFOs and the throttled ecdsa input
`timescale 1ns/10ps

module pp_source_arbiter
   import pp_beat_pkg::*, pp_meta_pkg::*;
(
   input  logic            clk,
   input  logic            rst,
   input  pp_beat_t        lh_beat,
   input  logic            lh_empty,
   input  pp_meta_t        lh_meta,
   input  logic            lh_meta_empty,
   input  logic            ecdsa_valid,
   input  pp_beat_t        ecdsa_beat,
   input  pp_meta_t        ecdsa_meta,
   output logic            lh_rd,
   output logic            lh_meta_rd,
   output logic            ecdsa_ready,
   pp_stream_if.src        stream
);

   logic sel_lh;
   logic ready_d1;       // Ready as the source saw it on the last edge
   logic ecdsa_take;
   logic pkt_open;
   logic pkt_open_nxt;
   logic ecdsa_drop;
   logic toggle;

   assign lh_rd = sel_lh & ~lh_empty;
   assign lh_meta_rd = lh_rd & lh_beat.eop;   // Meta leaves with the last beat
   assign ecdsa_take = ecdsa_valid & ready_d1;

   assign stream.valid = sel_lh ? ~lh_empty : ecdsa_take;
   assign stream.beat = sel_lh ? lh_beat : ecdsa_beat;

   always_comb begin
      stream.meta = sel_lh ? lh_meta : ecdsa_meta;
      stream.meta.src_ecdsa = sel_lh ? PP_SRC_LH : PP_SRC_ECDSA;
   end

   assign pkt_open_nxt = stream.valid ? ~stream.beat.eop : pkt_open;

   // Lower ready once lh is waiting and ecdsa sits at a packet boundary
   assign ecdsa_drop = ~lh_meta_empty & ~pkt_open_nxt &
                       (~ecdsa_valid | (ecdsa_take & ecdsa_beat.eop));

   // Leave ecdsa only after ready has been low for a cycle, so no beat is in flight
   assign toggle = sel_lh ? (lh_meta_rd | lh_meta_empty) & ecdsa_valid
                          : ~ecdsa_ready & ~pkt_open_nxt & ~lh_meta_empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         sel_lh <= 1'b1;
         ecdsa_ready <= 1'b0;
         ready_d1 <= 1'b0;
         pkt_open <= 1'b0;
      end else begin
         sel_lh <= sel_lh ^ toggle;
         ecdsa_ready <= ~(sel_lh ^ toggle) & ~ecdsa_drop;
         ready_d1 <= ecdsa_ready;
         pkt_open <= pkt_open_nxt;
      end
   end

   // Packets are never interleaved on the stream
   a_sel_held: assert property (@(posedge clk) disable iff (rst)
      pkt_open_nxt |=> $stable(sel_lh));

endmodule

// File: design/pp_stream_if.sv
// Beat stream with packet metadata from the source arbiter to the parse stage
`timescale 1ns/10ps

interface pp_stream_if
   import pp_beat_pkg::*, pp_meta_pkg::*;
   ();

   logic     valid;
   pp_beat_t beat;
   pp_meta_t meta;   // Valid with the sop beat, held for the packet

   modport src (
      output valid,
      output beat,
      output meta
   );

   // Extractor and credit tracker both observe the same beats
   modport snk (
      input valid,
      input beat,
      input meta
   );

endinterface

// File: pp_front_end.f
+incdir+design
design/pp_beat_pkg.sv
design/pp_meta_pkg.sv
design/pp_stream_if.sv
design/pp_fifo.sv
design/pp_source_arbiter.sv
design/pp_credit_tracker.sv
design/pp_chunk_extractor.sv
design/pp_front_end.sv
tb/pp_checker.sv
tb/tb_pp_front_end.sv

// File: tb/pp_checker.sv
// Output checker for the path parser front end: matches packets per source and tracks credits
`timescale 1ns/10ps
`include "pp_params.svh"

module pp_checker
   import pp_meta_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      ecdsa_ready,
   input  logic                      credit_return,
   input  logic                      pp_valid,
   input  logic                      pp_sop,
   input  logic                      pp_eop,
   input  logic [`PP_DATA_NBITS-1:0] pp_data,
   input  logic [`PP_VB_NBITS-1:0]   pp_valid_bytes,
   input  logic                      pp_meta_valid,
   input  pp_meta_t                  pp_meta,
   output int                        pkts_done,
   output int                        tests_run,
   output int                        tests_failed,
   output int                        errors
);

   typedef struct packed {
      logic [7:0]  idx;
      logic [7:0]  beats;
      logic [11:0] len;
      logic [3:0]  port;
      logic [15:0] fid;
      logic [15:0] rci;
      logic        discard;
   } exp_pkt_t;

   exp_pkt_t                  lh_pkt_q[$];
   exp_pkt_t                  ecdsa_pkt_q[$];
   logic [`PP_DATA_NBITS-1:0] lh_data_q[$];
   logic [`PP_DATA_NBITS-1:0] ecdsa_data_q[$];
   exp_pkt_t                  cur;
   logic                      cur_ecdsa;
   logic                      active;
   logic                      rst_q;
   int                        out_cnt;
   int                        exp_out;
   int                        credits;   // Model of the free downstream words
   int                        errors_at_start;

   function automatic int chunk_words(input int len);
      return (len + `PP_HDR_OVERHEAD + 15) / 16;
   endfunction

   task automatic expect_packet(input logic ecdsa, input int idx, input int beats,
                                input logic [11:0] len, input logic [3:0] port,
                                input logic [15:0] fid, input logic [15:0] rci,
                                input logic discard);
      exp_pkt_t pkt;
      pkt.idx = idx[7:0];
      pkt.beats = beats[7:0];
      pkt.len = len;
      pkt.port = port;
      pkt.fid = fid;
      pkt.rci = rci;
      pkt.discard = discard;
      if (ecdsa) ecdsa_pkt_q.push_back(pkt);
      else lh_pkt_q.push_back(pkt);
   endtask

   task automatic expect_beat(input logic ecdsa, input logic [`PP_DATA_NBITS-1:0] data);
      if (ecdsa) ecdsa_data_q.push_back(data);
      else lh_data_q.push_back(data);
   endtask

   task automatic pop_data(input logic ecdsa, output logic [`PP_DATA_NBITS-1:0] data);
      data = 'x;
      if (ecdsa && ecdsa_data_q.size() > 0) data = ecdsa_data_q.pop_front();
      else if (!ecdsa && lh_data_q.size() > 0) data = lh_data_q.pop_front();
   endtask

   task automatic check_value(input string name, input logic [`PP_DATA_NBITS-1:0] got,
                              input logic [`PP_DATA_NBITS-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (errors != errors_at_start) tests_failed++;
      $display("%s: %s", name, (errors == errors_at_start) ? "ok" : "mismatch");
   endtask

   task automatic finish_packet();
      logic [`PP_DATA_NBITS-1:0] skipped;
      int                        k;
      if (out_cnt != exp_out) begin
         $display("Fail at %0t ns: output beat count expected %0d, got %0d",
                  $time, exp_out, out_cnt);
         errors++;
      end
      for (k = out_cnt; k < cur.beats; k++) pop_data(cur_ecdsa, skipped);   // Beats past the chunk
      close_test($sformatf("Packet %0d %s", cur.idx, cur_ecdsa ? "ecdsa" : "lh"));
      pkts_done++;
      active = 1'b0;
   endtask

   task automatic start_packet();
      int   words;
      logic model_discard;
      if (active) begin
         $display("Packet %0d was still open when the next one started", cur.idx);
         errors++;
         finish_packet();
      end
      cur_ecdsa = pp_meta.src_ecdsa;
      if (cur_ecdsa ? ecdsa_pkt_q.size() == 0 : lh_pkt_q.size() == 0) begin
         $display("Unexpected pp_meta_valid at %0t ns with no packet pending", $time);
         errors++;
         return;
      end
      if (cur_ecdsa) cur = ecdsa_pkt_q.pop_front();
      else cur = lh_pkt_q.pop_front();
      errors_at_start = errors;
      words = chunk_words(cur.len);
      model_discard = words > credits;
      if (!model_discard) credits -= words;
      if (model_discard != cur.discard) begin
         $display("Packet %0d: credit model and data file disagree on discard", cur.idx);
         errors++;
      end
      check_value("pp_meta.discard", pp_meta.discard, model_discard);
      check_value("pp_meta.port", pp_meta.port, cur.port);
      check_value("pp_meta.fid", pp_meta.fid, cur.fid);
      check_value("pp_meta.rci", pp_meta.rci, cur.rci);
      exp_out = model_discard ? 0 : ((cur.beats < words) ? cur.beats : words);
      out_cnt = 0;
      active = 1'b1;
      if (exp_out == 0) finish_packet();   // Dropped packet shows only its meta
   endtask

   task automatic check_beat();
      logic [`PP_DATA_NBITS-1:0] exp_data;
      logic                      last;
      int                        vb;
      pop_data(cur_ecdsa, exp_data);
      last = out_cnt == exp_out - 1;
      vb = last ? (cur.len + `PP_HDR_OVERHEAD - 1) % 16 + 1 : 0;
      check_value("pp_data", pp_data, exp_data);
      check_value("pp_sop", pp_sop, out_cnt == 0);
      check_value("pp_eop", pp_eop, last);
      check_value("pp_valid_bytes", pp_valid_bytes, vb[`PP_VB_NBITS-1:0]);   // 16 reads as 0
      out_cnt++;
      if (last || pp_eop) finish_packet();
   endtask

   always @(posedge clk) begin
      rst_q <= rst;
      if (rst) begin
         credits = `PP_BUF_CREDITS;
         active = 1'b0;
         pkts_done = 0;
         tests_run = 0;
         tests_failed = 0;
         errors = 0;
      end else begin
         if (rst_q) begin
            errors_at_start = errors;
            check_value("pp_valid", pp_valid, 1'b0);
            check_value("pp_meta_valid", pp_meta_valid, 1'b0);
            check_value("ecdsa_ready", ecdsa_ready, 1'b0);
            close_test("Reset state");
         end
         if (credit_return) credits++;
         if (pp_meta_valid) start_packet();
         if (pp_valid) begin
            if (active) begin
               check_beat();
            end else begin
               $display("Unexpected pp_valid beat at %0t ns outside a packet", $time);
               errors++;
            end
         end
      end
   end

endmodule

// File: tb/pp_input.txt
// src (0 lh, 1 ecdsa)  beats  chunk_len  port  fid  rci  discard, all hex
// One packet per line in send order
0 04 02e 1 1001 0a0a 0
1 03 040 2 2002 0b0b 0
0 0a 1f0 3 3003 0c0c 1
1 08 00d 4 4004 0d0d 0
0 10 1e0 5 5005 0e0e 0
1 02 00e 6 6006 0f0f 0
1 05 03e 7 7007 1010 0
0 01 000 8 8008 1111 0
0 06 230 9 9009 1212 1
1 0c 0a0 a a00a 1313 0
0 03 15e b b00b 1414 1
1 07 05e c c00c 1515 0

// File: tb/tb_pp_front_end.sv
// Testbench for the path parser front end with file-driven packets and credit returns
`timescale 1ns/10ps
`include "pp_params.svh"

module tb_pp_front_end
   import pp_beat_pkg::*, pp_meta_pkg::*;
();

   localparam int NUM_PKTS = 12;
   localparam int NUM_FIELDS = 7;   // src beats len port fid rci discard

   logic                      clk = 1'b0;
   logic                      rst;
   logic                      lh_valid;
   logic                      lh_sop;
   logic                      lh_eop;
   logic [`PP_DATA_NBITS-1:0] lh_data;
   pp_meta_t                  lh_meta;
   logic                      ecdsa_valid;
   logic                      ecdsa_sop;
   logic                      ecdsa_eop;
   logic [`PP_DATA_NBITS-1:0] ecdsa_data;
   pp_meta_t                  ecdsa_meta;
   logic                      ecdsa_ready;
   logic                      pp_valid;
   logic                      pp_sop;
   logic                      pp_eop;
   logic [`PP_DATA_NBITS-1:0] pp_data;
   logic [`PP_VB_NBITS-1:0]   pp_valid_bytes;
   logic                      pp_meta_valid;
   pp_meta_t                  pp_meta;
   logic                      credit_return;
   logic [15:0]               pkt_words [NUM_PKTS*NUM_FIELDS];
   logic                      loaded = 1'b0;
   int                        seed = 84;
   int                        watchdog_cycles;
   int                        pkts_done;
   int                        tests_run;
   int                        tests_failed;
   int                        errors;

   always #5 clk = ~clk;

   pp_front_end pp_front_end_inst (
      .clk            (clk),
      .rst            (rst),
      .lh_valid       (lh_valid),
      .lh_sop         (lh_sop),
      .lh_eop         (lh_eop),
      .lh_data        (lh_data),
      .lh_meta        (lh_meta),
      .ecdsa_valid    (ecdsa_valid),
      .ecdsa_sop      (ecdsa_sop),
      .ecdsa_eop      (ecdsa_eop),
      .ecdsa_data     (ecdsa_data),
      .ecdsa_meta     (ecdsa_meta),
      .ecdsa_ready    (ecdsa_ready),
      .pp_valid       (pp_valid),
      .pp_sop         (pp_sop),
      .pp_eop         (pp_eop),
      .pp_data        (pp_data),
      .pp_valid_bytes (pp_valid_bytes),
      .pp_meta_valid  (pp_meta_valid),
      .pp_meta        (pp_meta),
      .credit_return  (credit_return)
   );

   pp_checker checker_inst (
      .clk            (clk),
      .rst            (rst),
      .ecdsa_ready    (ecdsa_ready),
      .credit_return  (credit_return),
      .pp_valid       (pp_valid),
      .pp_sop         (pp_sop),
      .pp_eop         (pp_eop),
      .pp_data        (pp_data),
      .pp_valid_bytes (pp_valid_bytes),
      .pp_meta_valid  (pp_meta_valid),
      .pp_meta        (pp_meta),
      .pkts_done      (pkts_done),
      .tests_run      (tests_run),
      .tests_failed   (tests_failed),
      .errors         (errors)
   );

   task automatic send_packet(input int p);
      logic                      ecdsa;
      int                        beats;
      int                        b;
      logic [`PP_DATA_NBITS-1:0] data;
      logic [`PP_DATA_NBITS-1:0] pkt_data [$];
      pp_meta_t                  meta;
      ecdsa = pkt_words[p*NUM_FIELDS][0];
      beats = pkt_words[p*NUM_FIELDS+1];
      meta = '0;
      meta.port = pkt_words[p*NUM_FIELDS+3][3:0];
      meta.fid = pkt_words[p*NUM_FIELDS+4];
      meta.rci = pkt_words[p*NUM_FIELDS+5];
      checker_inst.expect_packet(ecdsa, p, beats, pkt_words[p*NUM_FIELDS+2][11:0], meta.port,
                                 meta.fid, meta.rci, pkt_words[p*NUM_FIELDS+6][0]);
      for (b = 0; b < beats; b++) begin
         data = {$random(seed), $random(seed), $random(seed), $random(seed)};
         if (b == 0) data[PP_LEN_MSB:PP_LEN_LSB] = pkt_words[p*NUM_FIELDS+2][11:0];
         checker_inst.expect_beat(ecdsa, data);
         pkt_data.push_back(data);
      end
      for (b = 0; b < beats; b++) begin
         if (ecdsa) begin
            ecdsa_valid <= 1'b1;
            ecdsa_sop <= b == 0;
            ecdsa_eop <= b == beats - 1;
            ecdsa_data <= pkt_data[b];
            ecdsa_meta <= meta;
            @(posedge clk);
            while (!ecdsa_ready) @(posedge clk);   // Taken on an edge with ready high
         end else begin
            lh_valid <= 1'b1;
            lh_sop <= b == 0;
            lh_eop <= b == beats - 1;
            lh_data <= pkt_data[b];
            lh_meta <= meta;
            @(posedge clk);
         end
      end
      lh_valid <= 1'b0;
      ecdsa_valid <= 1'b0;
   endtask

   // Downstream frees one word per pulse
   task automatic return_credits(input int words);
      repeat (words) begin
         credit_return <= 1'b1;
         @(posedge clk);
      end
      credit_return <= 1'b0;
   endtask

   initial begin
      int p;
      int prev_charge;
      rst = 1'b1;
      lh_valid = 1'b0;
      lh_sop = 1'b0;
      lh_eop = 1'b0;
      lh_data = '0;
      lh_meta = '0;
      ecdsa_valid = 1'b0;
      ecdsa_sop = 1'b0;
      ecdsa_eop = 1'b0;
      ecdsa_data = '0;
      ecdsa_meta = '0;
      credit_return = 1'b0;
      $readmemh("tb/pp_input.txt", pkt_words);
      watchdog_cycles = 100 * NUM_PKTS;
      for (p = 0; p < NUM_PKTS; p++) watchdog_cycles += 20 * pkt_words[p*NUM_FIELDS+1];
      loaded = 1'b1;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      prev_charge = 0;
      for (p = 0; p < NUM_PKTS; p++) begin
         repeat (2 + $unsigned($random(seed)) % 4) @(posedge clk);
         send_packet(p);
         wait (pkts_done >= p + 1);
         @(posedge clk);
         // Credits lag by one packet so the buffer is not always full
         return_credits(prev_charge);
         prev_charge = pkt_words[p*NUM_FIELDS+6][0] ? 0 :
                       checker_inst.chunk_words(pkt_words[p*NUM_FIELDS+2]);
      end
      repeat (10) @(posedge clk);
      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (tests_failed == 0 && errors == 0 && pkts_done == NUM_PKTS) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      wait (loaded);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog: run did not finish within %0d cycles", watchdog_cycles);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule
